//--- testbench/exec_patterns.txt
# name opcode func3 func7 imm data1 data2 pc, then expected result pc_branch
# is_branch mem_rw is_load; all hex, held outputs carried forward from the line above
add_reg 33 0 00 0 5 7 0 c 0 0 0 0
sub_wrap 33 0 20 0 3 5 0 fffffffffffffffe 0 0 0 0
sll_reg 33 1 00 0 1 43 0 8 0 0 0 0
slt_signed 33 2 00 0 ffffffffffffffff 1 0 1 0 0 0 0
sltu_unsigned 33 3 00 0 ffffffffffffffff 1 0 0 0 0 0 0
xor_reg 33 4 00 0 ff00 ff0 0 f0f0 0 0 0 0
srl_reg 33 5 00 0 8000000000000000 3f 0 1 0 0 0 0
sra_neg 33 5 20 0 8000000000000000 24 0 fffffffff8000000 0 0 0 0
or_reg 33 6 00 0 f0 f 0 ff 0 0 0 0
and_reg 33 7 00 0 ff 3c 0 3c 0 0 0 0
addi_neg 13 0 00 fffffffffffffffc 10 99 0 c 0 0 0 0
andi 13 7 00 f0 abc 0 0 b0 0 0 0 0
sltiu 13 3 00 ffffffffffffffff 3 0 0 1 0 0 0 0
slli_wide 13 1 00 44 3 0 0 30 0 0 0 0
srai_wide 13 5 20 7c 8000000000000000 0 0 fffffffffffffff8 0 0 0 0
beq_taken 63 0 00 10 7 7 100 fffffffffffffff8 110 1 0 0
beq_not 63 0 00 10 7 8 200 fffffffffffffff8 204 0 0 0
bne_taken 63 1 00 fffffffffffffff0 1 2 300 fffffffffffffff8 2f0 1 0 0
bne_not 63 1 00 10 9 9 400 fffffffffffffff8 404 0 0 0
blt_taken 63 4 00 20 ffffffffffffffff 1 500 fffffffffffffff8 520 1 0 0
blt_not 63 4 00 20 5 5 600 fffffffffffffff8 604 0 0 0
bge_taken 63 5 00 40 5 5 700 fffffffffffffff8 740 1 0 0
bge_not 63 5 00 40 ffffffffffffffff 1 800 fffffffffffffff8 804 0 0 0
bltu_taken 63 6 00 40 1 ffffffffffffffff 900 fffffffffffffff8 940 1 0 0
bltu_not 63 6 00 8 ffffffffffffffff 1 a00 fffffffffffffff8 a04 0 0 0
bgeu_taken 63 7 00 8 ffffffffffffffff 1 b00 fffffffffffffff8 b08 1 0 0
bgeu_not 63 7 00 40 1 ffffffffffffffff c00 fffffffffffffff8 c04 0 0 0
jal 6f 0 00 800 0 0 1000 fffffffffffffff8 1800 1 0 0
jalr 67 0 00 4 2000 0 1000 fffffffffffffff8 2004 1 0 0
lui 37 0 00 12345 0 0 0 12345000 2004 1 0 0
auipc 17 0 00 1 0 0 4000 5000 2004 1 0 0
load_dword 03 3 00 0 0 0 0 5000 2004 1 0 1
store_dword 23 3 00 0 0 0 0 5000 2004 1 1 0
illegal 7f 0 00 0 0 0 0 0 2004 1 0 0

//--- src.f
rtl/exec_pkg.sv
rtl/exec_decode.sv
rtl/exec_compute.sv
rtl/exec_result_reg.sv
rtl/exec_unit.sv
testbench/exec_unit_assert.sv
testbench/exec_checker.sv
testbench/tb_exec_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PATTERNS := testbench/exec_patterns.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_exec_unit.sv
`timescale 1ns/1ns

module tb_exec_unit;

    localparam int xlen      = 64;
    localparam int pc_width  = 32;
    localparam int max_tests = 64;

    logic                clk;
    logic                rst;
    logic [6:0]          opcode;
    logic [2:0]          func3;
    logic [6:0]          func7;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     data1;
    logic [xlen-1:0]     data2;
    logic [pc_width-1:0] pc;
    logic [xlen-1:0]     result;
    logic [pc_width-1:0] pc_branch;
    logic                is_branch;
    logic                mem_rw;
    logic                is_load;

    // expected set for the checker, same cycle as the inputs
    logic                chk_valid;
    logic [8*16-1:0]     chk_name;
    logic [xlen-1:0]     exp_result;
    logic [pc_width-1:0] exp_pc_branch;
    logic                exp_is_branch;
    logic                exp_mem_rw;
    logic                exp_is_load;
    int                  checked;
    int                  failed;

    logic [8*16-1:0]     pat_name      [max_tests];
    logic [6:0]          pat_opcode    [max_tests];
    logic [2:0]          pat_func3     [max_tests];
    logic [6:0]          pat_func7     [max_tests];
    logic [xlen-1:0]     pat_imm       [max_tests];
    logic [xlen-1:0]     pat_data1     [max_tests];
    logic [xlen-1:0]     pat_data2     [max_tests];
    logic [pc_width-1:0] pat_pc        [max_tests];
    logic [xlen-1:0]     pat_result    [max_tests];
    logic [pc_width-1:0] pat_pc_branch [max_tests];
    logic                pat_is_branch [max_tests];
    logic                pat_mem_rw    [max_tests];
    logic                pat_is_load   [max_tests];

    int   num_tests = 0;
    int   cycles = 0;
    int   cycle_limit = 0;
    logic loaded = 1'b0;

    exec_unit #(
        .xlen     (xlen),
        .pc_width (pc_width)
    ) exec_unit_i (
        .clk       (clk),
        .rst       (rst),
        .opcode    (opcode),
        .func3     (func3),
        .func7     (func7),
        .imm       (imm),
        .data1     (data1),
        .data2     (data2),
        .pc        (pc),
        .result    (result),
        .pc_branch (pc_branch),
        .is_branch (is_branch),
        .mem_rw    (mem_rw),
        .is_load   (is_load)
    );

    exec_checker #(
        .xlen     (xlen),
        .pc_width (pc_width)
    ) exec_checker_i (
        .clk           (clk),
        .rst           (rst),
        .chk_valid     (chk_valid),
        .chk_name      (chk_name),
        .exp_result    (exp_result),
        .exp_pc_branch (exp_pc_branch),
        .exp_is_branch (exp_is_branch),
        .exp_mem_rw    (exp_mem_rw),
        .exp_is_load   (exp_is_load),
        .result        (result),
        .pc_branch     (pc_branch),
        .is_branch     (is_branch),
        .mem_rw        (mem_rw),
        .is_load       (is_load),
        .checked       (checked),
        .failed        (failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // comment lines fail the scan and are skipped
    task automatic load_patterns();
        int                fd;
        int                n;
        logic [8*160-1:0] line;
        fd = $fopen("testbench/exec_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/exec_patterns.txt");
        end else begin
            line = '0;
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                    pat_name[num_tests], pat_opcode[num_tests], pat_func3[num_tests],
                    pat_func7[num_tests], pat_imm[num_tests], pat_data1[num_tests],
                    pat_data2[num_tests], pat_pc[num_tests], pat_result[num_tests],
                    pat_pc_branch[num_tests], pat_is_branch[num_tests],
                    pat_mem_rw[num_tests], pat_is_load[num_tests]);
                if (n == 13 && num_tests < max_tests - 1) begin
                    num_tests++;
                end
                line = '0;
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_test(input int idx);
        opcode        <= pat_opcode[idx];
        func3         <= pat_func3[idx];
        func7         <= pat_func7[idx];
        imm           <= pat_imm[idx];
        data1         <= pat_data1[idx];
        data2         <= pat_data2[idx];
        pc            <= pat_pc[idx];
        chk_valid     <= 1'b1;
        chk_name      <= pat_name[idx];
        exp_result    <= pat_result[idx];
        exp_pc_branch <= pat_pc_branch[idx];
        exp_is_branch <= pat_is_branch[idx];
        exp_mem_rw    <= pat_mem_rw[idx];
        exp_is_load   <= pat_is_load[idx];
    endtask

    initial begin
        int i;
        rst           <= 1'b1;
        opcode        <= '0;
        func3         <= '0;
        func7         <= '0;
        imm           <= '0;
        data1         <= '0;
        data2         <= '0;
        pc            <= '0;
        chk_valid     <= 1'b0;
        chk_name      <= '0;
        exp_result    <= '0;
        exp_pc_branch <= '0;
        exp_is_branch <= 1'b0;
        exp_mem_rw    <= 1'b0;
        exp_is_load   <= 1'b0;
        load_patterns();
        loaded = 1'b1;
        if (num_tests == 0) begin
            $display("no test patterns were read, nothing to run");
            $display("Simulation failed");
        end else begin
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            for (i = 0; i < num_tests; i++) begin
                @(posedge clk);
                apply_test(i);
            end
            @(posedge clk);
            chk_valid <= 1'b0;
            // reset check counts as one more test
            wait (checked == num_tests + 1);
            $display("tests %0d, passed %0d, failed %0d", checked, checked - failed, failed);
            if (failed == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

    initial begin
        wait (loaded);
        cycle_limit = num_tests + 20;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d tests were checked",
            cycles, checked, num_tests + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/exec_checker.sv
`timescale 1ns/1ns

module exec_checker #(
    parameter int xlen     = 64,
    parameter int pc_width = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                chk_valid,
    input  logic [8*16-1:0]     chk_name,
    input  logic [xlen-1:0]     exp_result,
    input  logic [pc_width-1:0] exp_pc_branch,
    input  logic                exp_is_branch,
    input  logic                exp_mem_rw,
    input  logic                exp_is_load,
    input  logic [xlen-1:0]     result,
    input  logic [pc_width-1:0] pc_branch,
    input  logic                is_branch,
    input  logic                mem_rw,
    input  logic                is_load,
    output int                  checked,
    output int                  failed
);

    // expected values delayed to line up with the output register
    logic                valid_q;
    logic [8*16-1:0]     name_q;
    logic [xlen-1:0]     result_q;
    logic [pc_width-1:0] pc_branch_q;
    logic                is_branch_q;
    logic                mem_rw_q;
    logic                is_load_q;
    logic                rst_q;
    int                  n_checked = 0;
    int                  n_failed = 0;

    assign checked = n_checked;
    assign failed  = n_failed;

    always @(posedge clk) begin
        rst_q       <= rst;
        valid_q     <= chk_valid;
        name_q      <= chk_name;
        result_q    <= exp_result;
        pc_branch_q <= exp_pc_branch;
        is_branch_q <= exp_is_branch;
        mem_rw_q    <= exp_mem_rw;
        is_load_q   <= exp_is_load;
    end

    // outputs are stable half a cycle after the edge
    always @(negedge clk) begin
        if (rst_q === 1'b1 && rst === 1'b0) begin
            n_checked++;
            if ({result, pc_branch, is_branch, mem_rw, is_load} !== '0) begin
                n_failed++;
                $write("error reset: expected result %h pc_branch %h flags 000",
                    {xlen{1'b0}}, {pc_width{1'b0}});
                $display(", actual result %h pc_branch %h flags %b%b%b",
                    result, pc_branch, is_branch, mem_rw, is_load);
            end else begin
                $display("ok    reset");
            end
        end
        if (valid_q === 1'b1) begin
            n_checked++;
            if (result !== result_q || pc_branch !== pc_branch_q ||
                is_branch !== is_branch_q || mem_rw !== mem_rw_q || is_load !== is_load_q) begin
                n_failed++;
                $write("error %0s: expected result %h pc_branch %h flags %b%b%b", name_q,
                    result_q, pc_branch_q, is_branch_q, mem_rw_q, is_load_q);
                $display(", actual result %h pc_branch %h flags %b%b%b",
                    result, pc_branch, is_branch, mem_rw, is_load);
            end else begin
                $display("ok    %0s", name_q);
            end
        end
    end

endmodule

//--- testbench/exec_unit_assert.sv
`timescale 1ns/1ns

module exec_unit_assert #(
    parameter int xlen     = 64,
    parameter int pc_width = 32
) (
    input logic                clk,
    input logic                rst,
    input logic [xlen-1:0]     result,
    input logic [pc_width-1:0] pc_branch,
    input logic                is_branch,
    input logic                mem_rw,
    input logic                is_load
);

    // a store and a load are never flagged together
    mem_flags_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_rw && is_load)
    ) else $error("mem_rw and is_load are both high");

    // first edge after reset still sees reset values
    zero_after_reset: assert property (
        @(posedge clk) $fell(rst) |->
            (result == '0 && pc_branch == '0 && !is_branch && !mem_rw && !is_load)
    ) else $error("outputs are not zero in the cycle after reset");

endmodule

bind exec_unit exec_unit_assert #(
    .xlen     (xlen),
    .pc_width (pc_width)
) exec_unit_assert_i (
    .clk       (clk),
    .rst       (rst),
    .result    (result),
    .pc_branch (pc_branch),
    .is_branch (is_branch),
    .mem_rw    (mem_rw),
    .is_load   (is_load)
);

//--- rtl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit #(
    parameter int xlen     = exec_pkg::xlen_default,
    parameter int pc_width = exec_pkg::pc_width_default
) (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::opcode_t   opcode,
    input  exec_pkg::funct3_t   func3,
    input  exec_pkg::funct7_t   func7,
    input  logic [xlen-1:0]     imm,
    input  logic [xlen-1:0]     data1,
    input  logic [xlen-1:0]     data2,
    input  logic [pc_width-1:0] pc,
    output logic [xlen-1:0]     result,
    output logic [pc_width-1:0] pc_branch,
    output logic                is_branch,
    output logic                mem_rw,
    output logic                is_load
);
    import exec_pkg::*;

    // decode to compute
    alu_op_t  alu_op;
    logic     use_imm;
    br_cond_t br_cond;
    logic     jump_from_reg;

    // decode to result register
    logic wr_result;
    logic cls_branch;
    logic cls_jump;
    logic cls_load;
    logic cls_store;
    logic cls_illegal;

    // compute to result register
    logic [xlen-1:0]     alu_result;
    logic                br_taken;
    logic [pc_width-1:0] br_target;
    logic [pc_width-1:0] pc_next;

    exec_decode exec_decode_i (
        .opcode        (opcode),
        .func3         (func3),
        .func7         (func7),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .br_cond       (br_cond),
        .jump_from_reg (jump_from_reg),
        .wr_result     (wr_result),
        .cls_branch    (cls_branch),
        .cls_jump      (cls_jump),
        .cls_load      (cls_load),
        .cls_store     (cls_store),
        .cls_illegal   (cls_illegal)
    );

    exec_compute #(
        .xlen     (xlen),
        .pc_width (pc_width)
    ) exec_compute_i (
        .data1         (data1),
        .data2         (data2),
        .imm           (imm),
        .pc            (pc),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .br_cond       (br_cond),
        .jump_from_reg (jump_from_reg),
        .alu_result    (alu_result),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .pc_next       (pc_next)
    );

    exec_result_reg #(
        .xlen     (xlen),
        .pc_width (pc_width)
    ) exec_result_reg_i (
        .clk         (clk),
        .rst         (rst),
        .wr_result   (wr_result),
        .cls_branch  (cls_branch),
        .cls_jump    (cls_jump),
        .cls_load    (cls_load),
        .cls_store   (cls_store),
        .cls_illegal (cls_illegal),
        .alu_result  (alu_result),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .pc_next     (pc_next),
        .result      (result),
        .pc_branch   (pc_branch),
        .is_branch   (is_branch),
        .mem_rw      (mem_rw),
        .is_load     (is_load)
    );

endmodule

//--- rtl/exec_result_reg.sv
`timescale 1ns/1ns

module exec_result_reg #(
    parameter int xlen     = exec_pkg::xlen_default,
    parameter int pc_width = exec_pkg::pc_width_default
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_result,
    input  logic                cls_branch,
    input  logic                cls_jump,
    input  logic                cls_load,
    input  logic                cls_store,
    input  logic                cls_illegal,
    input  logic [xlen-1:0]     alu_result,
    input  logic                br_taken,
    input  logic [pc_width-1:0] br_target,
    input  logic [pc_width-1:0] pc_next,
    output logic [xlen-1:0]     result,
    output logic [pc_width-1:0] pc_branch,
    output logic                is_branch,
    output logic                mem_rw,
    output logic                is_load
);

    // classes are one-hot from decode, none set means hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= '0;
            pc_branch <= '0;
            is_branch <= 1'b0;
            mem_rw    <= 1'b0;
            is_load   <= 1'b0;
        end else if (wr_result) begin
            result  <= alu_result;
            mem_rw  <= 1'b0;
            is_load <= 1'b0;
        end else if (cls_branch) begin
            is_branch <= br_taken;
            pc_branch <= br_taken ? br_target : pc_next;
            mem_rw    <= 1'b0;
            is_load   <= 1'b0;
        end else if (cls_jump) begin
            is_branch <= 1'b1;
            pc_branch <= br_target;
            mem_rw    <= 1'b0;
            is_load   <= 1'b0;
        end else if (cls_load) begin
            mem_rw  <= 1'b0;
            is_load <= 1'b1;
        end else if (cls_store) begin
            mem_rw  <= 1'b1;
            is_load <= 1'b0;
        end else if (cls_illegal) begin
            result  <= '0;
            mem_rw  <= 1'b0;
            is_load <= 1'b0;
        end
    end

endmodule

//--- rtl/exec_compute.sv
`timescale 1ns/1ns

module exec_compute #(
    parameter int xlen     = exec_pkg::xlen_default,
    parameter int pc_width = exec_pkg::pc_width_default
) (
    input  logic [xlen-1:0]     data1,
    input  logic [xlen-1:0]     data2,
    input  logic [xlen-1:0]     imm,
    input  logic [pc_width-1:0] pc,
    input  exec_pkg::alu_op_t   alu_op,
    input  logic                use_imm,
    input  exec_pkg::br_cond_t  br_cond,
    input  logic                jump_from_reg,
    output logic [xlen-1:0]     alu_result,
    output logic                br_taken,
    output logic [pc_width-1:0] br_target,
    output logic [pc_width-1:0] pc_next
);
    import exec_pkg::*;

    logic [xlen-1:0]       operand_b;
    logic [shamt_bits-1:0] shamt;
    logic [xlen-1:0]       pc_ext;
    logic [xlen-1:0]       upper_imm;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic [xlen-1:0]       target_base;
    logic [xlen-1:0]       target_sum;
    logic                  br_eq;
    logic                  br_lt;
    logic                  br_ltu;

    assign operand_b = use_imm ? imm : data2;

    // only the low 6 bits shift
    assign shamt = operand_b[shamt_bits-1:0];

    assign pc_ext    = {{(xlen - pc_width){1'b0}}, pc};
    assign upper_imm = imm << 12;

    assign lt_signed   = $signed(data1) < $signed(operand_b);
    assign lt_unsigned = data1 < operand_b;

    always_comb begin
        case (alu_op)
            alu_add:   alu_result = data1 + operand_b;
            alu_sub:   alu_result = data1 - operand_b;
            alu_sll:   alu_result = data1 << shamt;
            alu_slt:   alu_result = {{(xlen - 1){1'b0}}, lt_signed};
            alu_sltu:  alu_result = {{(xlen - 1){1'b0}}, lt_unsigned};
            alu_xor:   alu_result = data1 ^ operand_b;
            alu_srl:   alu_result = data1 >> shamt;
            alu_sra:   alu_result = $signed(data1) >>> shamt;
            alu_or:    alu_result = data1 | operand_b;
            alu_and:   alu_result = data1 & operand_b;
            alu_lui:   alu_result = upper_imm;
            alu_auipc: alu_result = pc_ext + upper_imm;
            default:   alu_result = '0;
        endcase
    end

    // branch compare always on the two registers
    assign br_eq  = (data1 == data2);
    assign br_lt  = $signed(data1) < $signed(data2);
    assign br_ltu = data1 < data2;

    always_comb begin
        case (br_cond)
            br_beq:  br_taken = br_eq;
            br_bne:  br_taken = !br_eq;
            br_blt:  br_taken = br_lt;
            br_bge:  br_taken = !br_lt;
            br_bltu: br_taken = br_ltu;
            br_bgeu: br_taken = !br_ltu;
            // 010 and 011 are not branches
            default: br_taken = 1'b0;
        endcase
    end

    // jalr adds to rs1, everything else to pc
    assign target_base = jump_from_reg ? data1 : pc_ext;
    assign target_sum  = target_base + imm;
    assign br_target   = target_sum[pc_width-1:0];

    assign pc_next = pc + pc_width'(4);

endmodule

//--- rtl/exec_decode.sv
`timescale 1ns/1ns

module exec_decode (
    input  exec_pkg::opcode_t  opcode,
    input  exec_pkg::funct3_t  func3,
    input  exec_pkg::funct7_t  func7,
    output exec_pkg::alu_op_t  alu_op,
    output logic               use_imm,
    output exec_pkg::br_cond_t br_cond,
    output logic               jump_from_reg,
    output logic               wr_result,
    output logic               cls_branch,
    output logic               cls_jump,
    output logic               cls_load,
    output logic               cls_store,
    output logic               cls_illegal
);
    import exec_pkg::*;

    logic    imm_form;
    logic    f7_is_base;
    logic    f7_is_alt;
    alu_op_t arith_op;
    logic    arith_ok;

    assign imm_form   = (opcode == op_imm);
    assign f7_is_base = (func7 == f7_base);
    assign f7_is_alt  = (func7 == f7_alt);

    // integer op from func3, func7 qualifies it
    always_comb begin
        arith_op = alu_add;
        arith_ok = 1'b0;
        case (func3)
            f3_add: begin
                if (imm_form || f7_is_base) begin
                    arith_op = alu_add;
                    arith_ok = 1'b1;
                end else if (f7_is_alt) begin
                    arith_op = alu_sub;
                    arith_ok = 1'b1;
                end
            end
            // srli/srai look at func7 too
            f3_srl: begin
                arith_op = f7_is_alt ? alu_sra : alu_srl;
                arith_ok = f7_is_base || f7_is_alt;
            end
            f3_sll: begin
                arith_op = alu_sll;
                arith_ok = imm_form || f7_is_base;
            end
            f3_slt: begin
                arith_op = alu_slt;
                arith_ok = imm_form || f7_is_base;
            end
            f3_sltu: begin
                arith_op = alu_sltu;
                arith_ok = imm_form || f7_is_base;
            end
            f3_xor: begin
                arith_op = alu_xor;
                arith_ok = imm_form || f7_is_base;
            end
            f3_or: begin
                arith_op = alu_or;
                arith_ok = imm_form || f7_is_base;
            end
            default: begin
                arith_op = alu_and;
                arith_ok = imm_form || f7_is_base;
            end
        endcase
    end

    always_comb begin
        alu_op        = arith_op;
        use_imm       = imm_form;
        br_cond       = func3;
        jump_from_reg = 1'b0;
        wr_result     = 1'b0;
        cls_branch    = 1'b0;
        cls_jump      = 1'b0;
        cls_load      = 1'b0;
        cls_store     = 1'b0;
        cls_illegal   = 1'b0;
        case (opcode)
            op_reg, op_imm: wr_result = arith_ok;
            op_lui: begin
                alu_op    = alu_lui;
                wr_result = 1'b1;
            end
            op_auipc: begin
                alu_op    = alu_auipc;
                wr_result = 1'b1;
            end
            // undefined func3 still counts, compute never takes it
            op_branch: cls_branch = 1'b1;
            op_jal: cls_jump = 1'b1;
            op_jalr: begin
                cls_jump      = 1'b1;
                jump_from_reg = 1'b1;
            end
            op_load: begin
                case (func3)
                    f3_lb, f3_lh, f3_lw, f3_ld, f3_lbu, f3_lhu, f3_lwu: cls_load = 1'b1;
                    default: cls_load = 1'b0;
                endcase
            end
            op_store: begin
                case (func3)
                    f3_sb, f3_sh, f3_sw, f3_sd: cls_store = 1'b1;
                    default: cls_store = 1'b0;
                endcase
            end
            default: cls_illegal = 1'b1;
        endcase
    end

endmodule

//--- rtl/exec_pkg.sv
package exec_pkg;

    localparam int xlen_default     = 64;
    localparam int pc_width_default = 32;

    // shift amount width for 64-bit data
    localparam int shamt_bits = 6;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [2:0] br_cond_t;

    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_lui    = 7'b0110111;

    // integer ops
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_srl  = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // loads and stores
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_ld  = 3'b011;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;
    localparam funct3_t f3_lwu = 3'b110;
    localparam funct3_t f3_sb  = 3'b000;
    localparam funct3_t f3_sh  = 3'b001;
    localparam funct3_t f3_sw  = 3'b010;
    localparam funct3_t f3_sd  = 3'b011;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000;

    localparam alu_op_t alu_add   = 4'd0;
    localparam alu_op_t alu_sub   = 4'd1;
    localparam alu_op_t alu_sll   = 4'd2;
    localparam alu_op_t alu_slt   = 4'd3;
    localparam alu_op_t alu_sltu  = 4'd4;
    localparam alu_op_t alu_xor   = 4'd5;
    localparam alu_op_t alu_srl   = 4'd6;
    localparam alu_op_t alu_sra   = 4'd7;
    localparam alu_op_t alu_or    = 4'd8;
    localparam alu_op_t alu_and   = 4'd9;
    localparam alu_op_t alu_lui   = 4'd10;
    localparam alu_op_t alu_auipc = 4'd11;

    // same encoding as the branch func3
    localparam br_cond_t br_beq  = 3'b000;
    localparam br_cond_t br_bne  = 3'b001;
    localparam br_cond_t br_blt  = 3'b100;
    localparam br_cond_t br_bge  = 3'b101;
    localparam br_cond_t br_bltu = 3'b110;
    localparam br_cond_t br_bgeu = 3'b111;

endpackage
